//--- residuPatterns.txt
# Records: case <name> | base <aBase> <xBase> <yBase> (hex) <lg> (decimal)
# a <count> <a[0]..> | x <first index> <count> <x..> | y <count> <expected y..> | run
# impulse coefficient, y equals x
case impulse
base 000 040 080 4
a 11 1000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
x -10 10 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
x 0 4 0064 FF38 1234 8000
y 4 00000064 FFFFFF38 00001234 FFFF8000
run
# full order over 8 samples with history
case fullOrder
base 010 100 140 8
a 11 1000 F800 0400 0200 FE00 0100 0000 0080 FF80 0040 0020
x -10 10 0080 FF00 0180 0000 0100 FF80 0200 FE80 0080 0100
x 0 8 0280 FE00 0180 0100 FD00 0080 0000 0380
y 8 00000199 FFFFFD6C 0000030F 00000010 FFFFFC44 000002EF FFFFFED2 00000343
run
# saturation in L_mac and in the shift
case saturate
base 020 200 240 4
a 11 7FFF 7FFF 0000 0000 0000 0000 0000 0000 0000 0000 0000
x -10 10 0000 0000 0000 0000 0000 0000 0000 0000 0000 7FFF
x 0 4 7FFF 0000 8000 8000
y 4 00007FFF 00007FFF FFFF8000 FFFF8000
run
# first difference, negative outputs
case negative
base 030 2C0 300 3
a 11 1000 F000 0000 0000 0000 0000 0000 0000 0000 0000 0000
x -10 10 0000 0000 0000 0000 0000 0000 0000 0000 0000 0010
x 0 3 0005 FFF0 0100
y 3 FFFFFFF5 FFFFFFEB 00000110
run
# zero length writes nothing
case emptyLength
base 040 340 380 0
run
# new bases, half gain with rounding
case rebased
base 050 400 440 4
a 11 0800 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
x -10 10 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
x 0 4 0007 FFF9 0064 FFFF
y 4 00000004 FFFFFFFD 00000032 00000000
run

//--- all.f
residuPkg.sv
basicArith.sv
multMac.sv
shiftLeftSat.sv
scratchMemory.sv
residuControl.sv
residuTop.sv
residuTb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS = --binary --timing -Wno-fatal
TOP = residuTb
FILELIST = all.f
BUILD = obj_dir
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the residual filter testbench"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

//--- residuTb.sv
`timescale 1ns/100ps

module residuTb;

	import residuPkg::*;

	localparam int ORDER = 10;
	localparam int SHIFT = 3;
	localparam int driveDelay = 10;

	logic clk;
	logic reset;
	logic start;
	logic [addrWidth-1:0] aBase;
	logic [addrWidth-1:0] xBase;
	logic [addrWidth-1:0] yBase;
	logic [lenWidth-1:0] lg;
	logic loadEn;
	logic [addrWidth-1:0] loadAddr;
	word32 loadData;
	logic [addrWidth-1:0] readAddr;
	logic done;
	logic busy;
	word32 readData;

	// Cases from the pattern file
	logic [8*32-1:0] caseNames [$];
	logic [addrWidth-1:0] caseABase [$];
	logic [addrWidth-1:0] caseXBase [$];
	logic [addrWidth-1:0] caseYBase [$];
	logic [lenWidth-1:0] caseLg [$];
	int loadStarts [$];
	int loadEnds [$];
	int checkStarts [$];
	int checkEnds [$];

	// Memory writes and expected words over all cases
	logic [addrWidth-1:0] loadAddrs [$];
	word32 loadWords [$];
	logic [addrWidth-1:0] checkAddrs [$];
	word32 checkWords [$];

	int valueErrors = 0;
	int otherErrors = 0;
	int budgetCycles = 20;
	logic budgetReady = 1'b0;

	residuTop #(.ORDER(ORDER), .SHIFT(SHIFT)) dut0 (
		.clk(clk), .reset(reset), .start(start),
		.aBase(aBase), .xBase(xBase), .yBase(yBase), .lg(lg),
		.loadEn(loadEn), .loadAddr(loadAddr), .loadData(loadData),
		.readAddr(readAddr), .done(done), .busy(busy), .readData(readData)
	);

	always
	begin
		clk = 1'b0;
		#50;
		clk = 1'b1;
		#50;
	end

	//////////////////////////////
	// Helpers
	//////////////////////////////

	function automatic word32 signExtend16(int raw);
		word16 low;
		low = raw[15:0];
		return word32'(low);
	endfunction

	// Marker word for an output address
	function automatic word32 sentinelFor(int addr);
		return 32'hA5A5_0000 | word32'(addr & 32'h7FF);
	endfunction

	// Inputs change and outputs are sampled just after the edge
	task automatic stepCycle();
		@(posedge clk);
		#driveDelay;
	endtask

	task automatic readPatterns();
		int fd;
		int code;
		int count;
		int first;
		int value;
		int k;
		int aB;
		int xB;
		int yB;
		int len;
		int loadStart;
		int checkStart;
		logic [8*16-1:0] tag;
		logic [8*128-1:0] line;
		logic [8*32-1:0] name;

		aB = 0;
		xB = 0;
		yB = 0;
		len = 0;
		loadStart = 0;
		checkStart = 0;
		name = '0;
		fd = $fopen("residuPatterns.txt", "r");
		if (fd == 0)
		begin
			otherErrors++;
			$display("Cannot open the pattern file residuPatterns.txt");
			return;
		end
		while ($fscanf(fd, "%s", tag) == 1)
		begin
			if (tag == "#")
				code = $fgets(line, fd);
			else if (tag == "case")
			begin
				code = $fscanf(fd, "%s", name);
				loadStart = loadAddrs.size();
				checkStart = checkAddrs.size();
			end
			else if (tag == "base")
				code = $fscanf(fd, "%h %h %h %d", aB, xB, yB, len);
			else if (tag == "a")
			begin
				code = $fscanf(fd, "%d", count);
				for (k = 0; k < count; k++)
				begin
					code = $fscanf(fd, "%h", value);
					loadAddrs.push_back(addrWidth'(aB + k));
					loadWords.push_back(signExtend16(value));
				end
			end
			else if (tag == "x")
			begin
				// First index may be negative for history samples
				code = $fscanf(fd, "%d %d", first, count);
				for (k = 0; k < count; k++)
				begin
					code = $fscanf(fd, "%h", value);
					loadAddrs.push_back(addrWidth'(xB + first + k));
					loadWords.push_back(signExtend16(value));
				end
			end
			else if (tag == "y")
			begin
				code = $fscanf(fd, "%d", count);
				for (k = 0; k < count; k++)
				begin
					code = $fscanf(fd, "%h", value);
					checkAddrs.push_back(addrWidth'(yB + k));
					checkWords.push_back(word32'(value));
				end
			end
			else if (tag == "run")
			begin
				// Output words and the word past them start as markers
				for (k = 0; k <= len; k++)
				begin
					loadAddrs.push_back(addrWidth'(yB + k));
					loadWords.push_back(sentinelFor(yB + k));
				end
				checkAddrs.push_back(addrWidth'(yB + len));
				checkWords.push_back(sentinelFor(yB + len));
				caseNames.push_back(name);
				caseABase.push_back(addrWidth'(aB));
				caseXBase.push_back(addrWidth'(xB));
				caseYBase.push_back(addrWidth'(yB));
				caseLg.push_back(lenWidth'(len));
				loadStarts.push_back(loadStart);
				loadEnds.push_back(loadAddrs.size());
				checkStarts.push_back(checkStart);
				checkEnds.push_back(checkAddrs.size());
				budgetCycles += 2 * (len * (3 * ORDER + SHIFT + 8) + 20);
			end
			else
			begin
				otherErrors++;
				$display("Unknown record %0s in the pattern file", tag);
			end
		end
		$fclose(fd);
	endtask

	task automatic runCase(int c);
		int k;

		assert (!busy)
		else
		begin
			otherErrors++;
			$display("busy is high before case %0s", caseNames[c]);
		end

		for (k = loadStarts[c]; k < loadEnds[c]; k++)
		begin
			loadEn = 1'b1;
			loadAddr = loadAddrs[k];
			loadData = loadWords[k];
			stepCycle();
		end
		loadEn = 1'b0;

		aBase = caseABase[c];
		xBase = caseXBase[c];
		yBase = caseYBase[c];
		lg = caseLg[c];
		start = 1'b1;
		stepCycle();
		start = 1'b0;
		while (!done)
			stepCycle();

		// done lasts one cycle and the FSM returns to idle
		stepCycle();
		assert (!done)
		else
		begin
			otherErrors++;
			$display("done stayed high for more than one cycle in case %0s", caseNames[c]);
		end
		assert (!busy)
		else
		begin
			otherErrors++;
			$display("busy is still high after done in case %0s", caseNames[c]);
		end

		for (k = checkStarts[c]; k < checkEnds[c]; k++)
		begin
			readAddr = checkAddrs[k];
			stepCycle();
			assert (readData === checkWords[k])
			else
			begin
				valueErrors++;
				$display("error: case %0s address %h expected %h actual %h",
					caseNames[c], checkAddrs[k], checkWords[k], readData);
			end
		end
	endtask

	//////////////////////////////
	// Main sequence
	//////////////////////////////

	initial
	begin
		int seedValue;
		int c;
		int gap;

		reset = 1'b1;
		start = 1'b0;
		aBase = '0;
		xBase = '0;
		yBase = '0;
		lg = '0;
		loadEn = 1'b0;
		loadAddr = '0;
		loadData = '0;
		readAddr = '0;
		seedValue = $urandom(65308);

		readPatterns();
		if (caseNames.size() == 0)
		begin
			otherErrors++;
			$display("The pattern file holds no runnable case");
		end
		budgetReady = 1'b1;

		repeat (2) @(posedge clk);
		#driveDelay;
		reset = 1'b0;
		assert (!busy && !done)
		else
		begin
			otherErrors++;
			$display("busy or done is high after reset");
		end

		// Cases run back to back without another reset
		for (c = 0; c < caseNames.size(); c++)
		begin
			gap = 1 + ($urandom % 8);
			repeat (gap) stepCycle();
			runCase(c);
		end

		$display("Checks done: %0d value errors, %0d other errors", valueErrors, otherErrors);
		if (valueErrors == 0 && otherErrors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

	// Watchdog sized from the case lengths
	initial
	begin
		wait (budgetReady);
		repeat (budgetCycles) @(posedge clk);
		$display("The run did not finish within %0d clock cycles and was stopped", budgetCycles);
		$display("SIMULATION FAILED");
		$finish;
	end

endmodule

//--- residuTop.sv
`timescale 1ns/100ps

module residuTop #(
	parameter int ORDER = 10,
	parameter int SHIFT = 3
) (
	input  logic clk,
	input  logic reset,
	input  logic start,
	input  logic [residuPkg::addrWidth-1:0] aBase,
	input  logic [residuPkg::addrWidth-1:0] xBase,
	input  logic [residuPkg::addrWidth-1:0] yBase,
	input  logic [residuPkg::lenWidth-1:0] lg,
	input  logic loadEn,
	input  logic [residuPkg::addrWidth-1:0] loadAddr,
	input  residuPkg::word32 loadData,
	input  logic [residuPkg::addrWidth-1:0] readAddr,
	output logic done,
	output logic busy,
	output residuPkg::word32 readData
);

	import residuPkg::*;

	// Memory side
	logic [addrWidth-1:0] readAddr1, readAddr2, writeAddr;
	logic writeEn;
	word32 writeData, readData1, readData2;

	// Operator side
	word16 multA, multB, macA, macB;
	word32 macAcc, multResult, macResult;
	logic shiftReady, shiftDone;
	word32 shiftIn, shiftOut;
	word16 addA, addB, subA, subB, addResult, subResult, roundResult;
	word32 roundIn;

	residuControl #(.ORDER(ORDER)) control0 (
		.clk(clk), .reset(reset), .start(start),
		.aBase(aBase), .xBase(xBase), .yBase(yBase), .lg(lg),
		.done(done), .busy(busy),
		.readAddr1(readAddr1), .readAddr2(readAddr2),
		.writeEn(writeEn), .writeAddr(writeAddr), .writeData(writeData),
		.readData1(readData1), .readData2(readData2),
		.multA(multA), .multB(multB), .macA(macA), .macB(macB), .macAcc(macAcc),
		.multResult(multResult), .macResult(macResult),
		.shiftReady(shiftReady), .shiftIn(shiftIn),
		.shiftOut(shiftOut), .shiftDone(shiftDone),
		.addA(addA), .addB(addB), .subA(subA), .subB(subB), .roundIn(roundIn),
		.addResult(addResult), .subResult(subResult), .roundResult(roundResult)
	);

	scratchMemory memory0 (
		.clk(clk), .readAddr1(readAddr1), .readAddr2(readAddr2),
		.writeEn(writeEn), .writeAddr(writeAddr), .writeData(writeData),
		.busy(busy), .loadEn(loadEn), .loadAddr(loadAddr), .loadData(loadData),
		.readAddr(readAddr), .readData1(readData1), .readData2(readData2),
		.readData(readData)
	);

	multMac multMac0 (
		.multA(multA), .multB(multB), .macA(macA), .macB(macB), .macAcc(macAcc),
		.multResult(multResult), .macResult(macResult)
	);

	shiftLeftSat #(.SHIFT(SHIFT)) shifter0 (
		.clk(clk), .reset(reset), .shiftReady(shiftReady), .shiftIn(shiftIn),
		.shiftOut(shiftOut), .shiftDone(shiftDone)
	);

	basicArith arith0 (
		.addA(addA), .addB(addB), .subA(subA), .subB(subB), .roundIn(roundIn),
		.addResult(addResult), .subResult(subResult), .roundResult(roundResult)
	);

endmodule

//--- residuControl.sv
`timescale 1ns/100ps

module residuControl #(
	parameter int ORDER = 10
) (
	input  logic clk,
	input  logic reset,
	input  logic start,
	input  logic [residuPkg::addrWidth-1:0] aBase,
	input  logic [residuPkg::addrWidth-1:0] xBase,
	input  logic [residuPkg::addrWidth-1:0] yBase,
	input  logic [residuPkg::lenWidth-1:0] lg,
	output logic done,
	output logic busy,
	output logic [residuPkg::addrWidth-1:0] readAddr1,
	output logic [residuPkg::addrWidth-1:0] readAddr2,
	output logic writeEn,
	output logic [residuPkg::addrWidth-1:0] writeAddr,
	output residuPkg::word32 writeData,
	input  residuPkg::word32 readData1,
	input  residuPkg::word32 readData2,
	output residuPkg::word16 multA,
	output residuPkg::word16 multB,
	output residuPkg::word16 macA,
	output residuPkg::word16 macB,
	output residuPkg::word32 macAcc,
	input  residuPkg::word32 multResult,
	input  residuPkg::word32 macResult,
	output logic shiftReady,
	output residuPkg::word32 shiftIn,
	input  residuPkg::word32 shiftOut,
	input  logic shiftDone,
	output residuPkg::word16 addA,
	output residuPkg::word16 addB,
	output residuPkg::word16 subA,
	output residuPkg::word16 subB,
	output residuPkg::word32 roundIn,
	input  residuPkg::word16 addResult,
	input  residuPkg::word16 subResult,
	input  residuPkg::word16 roundResult
);

	import residuPkg::*;

	controlState state, nextState;

	// Sample counter i and tap counter j, j needs one bit past ORDER
	logic [lenWidth-1:0] i, nextI;
	logic [4:0] j, nextJ;

	// Fetched operand and accumulator
	word32 temp, nextTemp;
	word32 sum, nextSum;

	//////////////////////////////
	// Registers
	//////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= idle;
			i <= '0;
			j <= 5'd1;
		end
		else
		begin
			state <= nextState;
			i <= nextI;
			j <= nextJ;
		end
	end

	always_ff @(posedge clk)
	begin
		temp <= nextTemp;
		sum <= nextSum;
	end

	assign busy = (state != idle);
	assign done = (state == finish);

	//////////////////////////////
	// Next state and datapath control
	//////////////////////////////

	always_comb
	begin
		nextState = state;
		nextI = i;
		nextJ = j;
		nextTemp = temp;
		nextSum = sum;
		readAddr1 = '0;
		readAddr2 = '0;
		writeEn = 1'b0;
		writeAddr = '0;
		writeData = '0;
		multA = '0;
		multB = '0;
		macA = '0;
		macB = '0;
		macAcc = '0;
		shiftReady = 1'b0;
		shiftIn = '0;
		addA = '0;
		addB = '0;
		subA = '0;
		subB = '0;
		roundIn = '0;

		unique case (state)
			idle:
			begin
				nextI = '0;
				nextJ = 5'd1;
				if (start)
					nextState = outerLoop;
			end

			outerLoop:
			begin
				if (i < lg)
				begin
					// Fetch x[i]
					readAddr2 = {xBase[addrWidth-1:6], i};
					nextState = readSample;
				end
				else
					nextState = finish;
			end

			readSample:
			begin
				readAddr1 = aBase;
				nextTemp = readData2;
				nextState = multiply;
			end

			multiply:
			begin
				// a[0] * x[i]
				multA = temp[15:0];
				multB = readData1[15:0];
				nextSum = multResult;
				nextState = innerLoop;
			end

			innerLoop:
			begin
				if (j <= ORDER)
				begin
					readAddr1 = {aBase[addrWidth-1:4], j[3:0]};
					nextState = readTap;
				end
				else
					nextState = shift;
			end

			readTap:
			begin
				// Tap address xBase + (i - j), may fall below xBase into history
				subA = word16'(i);
				subB = word16'(j);
				addA = word16'(xBase);
				addB = subResult;
				readAddr2 = addResult[addrWidth-1:0];
				nextTemp = readData1;
				nextState = accumulate;
			end

			accumulate:
			begin
				macA = temp[15:0];
				macB = readData2[15:0];
				macAcc = sum;
				nextSum = macResult;
				addA = word16'(j);
				addB = 16'sd1;
				nextJ = addResult[4:0];
				nextState = innerLoop;
			end

			shift:
			begin
				shiftIn = sum;
				shiftReady = 1'b1;
				if (shiftDone)
				begin
					shiftReady = 1'b0;
					nextSum = shiftOut;
					nextState = roundStore;
				end
			end

			roundStore:
			begin
				roundIn = sum;
				writeData = word32'(roundResult);
				writeAddr = {yBase[addrWidth-1:6], i};
				writeEn = 1'b1;
				addA = word16'(i);
				addB = 16'sd1;
				nextI = addResult[lenWidth-1:0];
				nextJ = 5'd1;
				nextState = outerLoop;
			end

			finish:
				nextState = idle;

			default:
				nextState = idle;
		endcase
	end

endmodule

//--- scratchMemory.sv
`timescale 1ns/100ps

module scratchMemory (
	input  logic clk,
	input  logic [residuPkg::addrWidth-1:0] readAddr1,
	input  logic [residuPkg::addrWidth-1:0] readAddr2,
	input  logic writeEn,
	input  logic [residuPkg::addrWidth-1:0] writeAddr,
	input  residuPkg::word32 writeData,
	input  logic busy,
	input  logic loadEn,
	input  logic [residuPkg::addrWidth-1:0] loadAddr,
	input  residuPkg::word32 loadData,
	input  logic [residuPkg::addrWidth-1:0] readAddr,
	output residuPkg::word32 readData1,
	output residuPkg::word32 readData2,
	output residuPkg::word32 readData
);

	import residuPkg::*;

	word32 mem [0:(1 << addrWidth)-1];

	logic portWriteEn;
	logic [addrWidth-1:0] portWriteAddr;
	logic [addrWidth-1:0] port2Addr;
	word32 portWriteData;

	// Load and read path own the ports while the filter is idle
	assign portWriteEn = busy ? writeEn : loadEn;
	assign portWriteAddr = busy ? writeAddr : loadAddr;
	assign portWriteData = busy ? writeData : loadData;
	assign port2Addr = busy ? readAddr2 : readAddr;

	always_ff @(posedge clk)
	begin
		if (portWriteEn)
			mem[portWriteAddr] <= portWriteData;
		readData1 <= mem[readAddr1];
		readData2 <= mem[port2Addr];
	end

	assign readData = busy ? '0 : readData2;

endmodule

//--- shiftLeftSat.sv
`timescale 1ns/100ps

module shiftLeftSat #(
	parameter int SHIFT = 3
) (
	input  logic clk,
	input  logic reset,
	input  logic shiftReady,
	input  residuPkg::word32 shiftIn,
	output residuPkg::word32 shiftOut,
	output logic shiftDone
);

	import residuPkg::*;

	localparam int countWidth = (SHIFT > 1) ? $clog2(SHIFT + 1) : 1;

	logic running;
	logic [countWidth-1:0] count;
	word32 value;

	// One step of L_shl, saturated values keep their top two bits apart
	function automatic word32 stepShift(word32 x);
		if (x[31] != x[30])
			return x[31] ? 32'sh8000_0000 : 32'sh7FFF_FFFF;
		else
			return x <<< 1;
	endfunction

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			running <= 1'b0;
			shiftDone <= 1'b0;
			count <= '0;
		end
		else
		begin
			shiftDone <= 1'b0;
			if (!running && !shiftDone && shiftReady)
			begin
				// Load on the first ready cycle
				value <= shiftIn;
				count <= '0;
				running <= (SHIFT > 0);
				shiftDone <= (SHIFT == 0);
			end
			else if (running)
			begin
				value <= stepShift(value);
				count <= count + 1'b1;
				if (count == countWidth'(SHIFT - 1))
				begin
					running <= 1'b0;
					shiftDone <= 1'b1;
				end
			end
		end
	end

	assign shiftOut = value;

endmodule

//--- multMac.sv
`timescale 1ns/100ps

module multMac (
	input  residuPkg::word16 multA,
	input  residuPkg::word16 multB,
	input  residuPkg::word16 macA,
	input  residuPkg::word16 macB,
	input  residuPkg::word32 macAcc,
	output residuPkg::word32 multResult,
	output residuPkg::word32 macResult
);

	import residuPkg::*;

	// Doubled product, the only overflow case is 0x8000 * 0x8000
	function automatic word32 lMult(word16 x, word16 y);
		word32 product;
		product = x * y;
		if (product == 32'sh4000_0000)
			return 32'sh7FFF_FFFF;
		else
			return product <<< 1;
	endfunction

	// 32-bit add with saturation
	function automatic word32 lAdd(word32 x, word32 y);
		logic signed [32:0] wide;
		wide = {x[31], x} + {y[31], y};
		if (wide[32] != wide[31])
			return wide[32] ? 32'sh8000_0000 : 32'sh7FFF_FFFF;
		else
			return wide[31:0];
	endfunction

	word32 macProduct;

	assign multResult = lMult(multA, multB);

	//////////////////////////////
	// L_mac
	//////////////////////////////

	assign macProduct = lMult(macA, macB);
	assign macResult = lAdd(macAcc, macProduct);

endmodule

//--- basicArith.sv
`timescale 1ns/100ps

module basicArith (
	input  residuPkg::word16 addA,
	input  residuPkg::word16 addB,
	input  residuPkg::word16 subA,
	input  residuPkg::word16 subB,
	input  residuPkg::word32 roundIn,
	output residuPkg::word16 addResult,
	output residuPkg::word16 subResult,
	output residuPkg::word16 roundResult
);

	import residuPkg::*;

	logic signed [16:0] addWide;
	logic signed [16:0] subWide;
	logic signed [32:0] roundWide;

	// Clamp a 17-bit result into a codec word
	function automatic word16 sat16(logic signed [16:0] x);
		if (x[16] != x[15])
			return x[16] ? 16'sh8000 : 16'sh7FFF;
		else
			return x[15:0];
	endfunction

	assign addWide = {addA[15], addA} + {addB[15], addB};
	assign subWide = {subA[15], subA} - {subB[15], subB};
	assign addResult = sat16(addWide);
	assign subResult = sat16(subWide);

	//////////////////////////////
	// round = upper half of L_add(x, 0x8000)
	//////////////////////////////

	assign roundWide = {roundIn[31], roundIn} + 33'sh0_0000_8000;
	assign roundResult = (roundWide[32] != roundWide[31]) ?
		(roundWide[32] ? 16'sh8000 : 16'sh7FFF) : roundWide[31:16];

endmodule

//--- residuPkg.sv
package residuPkg;

	// Scratch memory addressing
	localparam int addrWidth = 11;

	// Width of lg and of the sample counter
	localparam int lenWidth = 6;

	// Codec words
	typedef logic signed [15:0] word16;
	typedef logic signed [31:0] word32;

	// Controller states
	typedef enum logic [3:0]
	{
		idle,
		outerLoop,
		readSample,
		multiply,
		innerLoop,
		readTap,
		accumulate,
		shift,
		roundStore,
		finish
	} controlState;

endpackage
